/* list.f */
rv_wb_pkg.sv
rv_mul_fixup.sv
rv_result_sel.sv
rv_pipe_ctrl.sv
rv_retire_reg.sv
rv_stage_wb.sv
tb_rv_stage_wb.sv

/* run.sh */
#!/bin/sh
# Build and run the write-back stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_rv_stage_wb -f list.f

out=$(./obj_dir/Vtb_rv_stage_wb)
printf '%s\n' "$out"

# Pass only when the testbench printed the pass line
printf '%s\n' "$out" | grep -qx "All tests passed"

/* tb_rv_stage_wb.sv */
`timescale 1ns/1ps

module tb_rv_stage_wb;

  localparam int XLEN     = 32;
  localparam int NUM_TX   = 400;
  localparam int BURST_LO = 200;
  localparam int BURST_HI = 240;

  typedef struct packed {
    rv_wb_pkg::instr_t     instr;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [XLEN-1:0]       rd;
    logic                  trap;
    rv_wb_pkg::trap_code_t trap_code;
    logic                  reg_write;
    logic                  ebreak;
  } ret_rec_t;

  logic clk;
  logic reset_i;
  logic s_valid_i;
  logic s_ready_o;
  rv_wb_pkg::res_src_t   res_src_wb_i;
  rv_wb_pkg::instr_t     instr_wb_i;
  logic [XLEN-1:0]       alu_result_wb_i;
  logic [XLEN-1:0]       ld_data_wb_i;
  logic [XLEN-1:0]       pc_plus4_wb_i;
  logic [XLEN-1:0]       jb_tgt_wb_i;
  logic [XLEN-1:0]       csr_rdata_wb_i;
  logic [XLEN-1:0]       div_result_wb_i;
  rv_wb_pkg::funct3_t    funct3_wb_i;
  logic [XLEN-1:0]       rs1_data_wb_i;
  logic [XLEN-1:0]       rs2_data_wb_i;
  logic [2*XLEN-1:0]     product_wb_i;
  logic                  trap_wb_i;
  rv_wb_pkg::trap_code_t trap_code_wb_i;
  logic                  ebreak_wb_i;
  logic                  reg_write_wb_i;
  logic                  m_valid_o;
  logic                  m_ready_i;
  rv_wb_pkg::instr_t     instr_ret_o;
  logic [XLEN-1:0]       pc_ret_o;
  logic [XLEN-1:0]       rs1_data_ret_o;
  logic [XLEN-1:0]       rs2_data_ret_o;
  logic [XLEN-1:0]       rd_data_ret_o;
  logic                  trap_ret_o;
  rv_wb_pkg::trap_code_t trap_code_ret_o;
  logic                  reg_write_ret_o;
  logic                  ebreak_ret_o;
  logic [XLEN-1:0]       rd_data_wb_o;

  integer   seed = 32'h2602_509c;
  int       data_errs = 0;
  int       proto_errs = 0;
  int       sent = 0;
  int       retired = 0;
  int       streak = 0;
  int       max_streak = 0;
  logic     hold;
  logic     burst;
  logic     accepted_last = 1'b0;
  logic [XLEN-1:0] exp_rd;
  ret_rec_t cur_rec;
  ret_rec_t new_rec;
  ret_rec_t exp_q[$];

  rv_stage_wb #(
    .XLEN(XLEN)
  ) dut0 (
    .clk            (clk),
    .reset_i        (reset_i),
    .s_valid_i      (s_valid_i),
    .s_ready_o      (s_ready_o),
    .res_src_wb_i   (res_src_wb_i),
    .instr_wb_i     (instr_wb_i),
    .alu_result_wb_i(alu_result_wb_i),
    .ld_data_wb_i   (ld_data_wb_i),
    .pc_plus4_wb_i  (pc_plus4_wb_i),
    .jb_tgt_wb_i    (jb_tgt_wb_i),
    .csr_rdata_wb_i (csr_rdata_wb_i),
    .div_result_wb_i(div_result_wb_i),
    .funct3_wb_i    (funct3_wb_i),
    .rs1_data_wb_i  (rs1_data_wb_i),
    .rs2_data_wb_i  (rs2_data_wb_i),
    .product_wb_i   (product_wb_i),
    .trap_wb_i      (trap_wb_i),
    .trap_code_wb_i (trap_code_wb_i),
    .ebreak_wb_i    (ebreak_wb_i),
    .reg_write_wb_i (reg_write_wb_i),
    .m_valid_o      (m_valid_o),
    .m_ready_i      (m_ready_i),
    .instr_ret_o    (instr_ret_o),
    .pc_ret_o       (pc_ret_o),
    .rs1_data_ret_o (rs1_data_ret_o),
    .rs2_data_ret_o (rs2_data_ret_o),
    .rd_data_ret_o  (rd_data_ret_o),
    .trap_ret_o     (trap_ret_o),
    .trap_code_ret_o(trap_code_ret_o),
    .reg_write_ret_o(reg_write_ret_o),
    .ebreak_ret_o   (ebreak_ret_o),
    .rd_data_wb_o   (rd_data_wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Expected write-back value, multiply results from 64-bit arithmetic
  function automatic logic [XLEN-1:0] ref_rd_data(
    input rv_wb_pkg::res_src_t res_src,
    input rv_wb_pkg::funct3_t  funct3,
    input logic [XLEN-1:0]     alu,
    input logic [XLEN-1:0]     ld,
    input logic [XLEN-1:0]     pc4,
    input logic [XLEN-1:0]     jb,
    input logic [XLEN-1:0]     csr,
    input logic [XLEN-1:0]     div,
    input logic [XLEN-1:0]     rs1,
    input logic [XLEN-1:0]     rs2
  );
    logic signed [63:0] s_a;
    logic signed [63:0] s_b;
    logic signed [63:0] s_p;
    logic [63:0]        u_p;
    logic [XLEN-1:0]    m_ext;
    begin
      u_p = {32'b0, rs1} * {32'b0, rs2};
      s_a = {{32{rs1[31]}}, rs1};
      case (funct3)
        rv_wb_pkg::MUL_LO: m_ext = u_p[31:0];
        rv_wb_pkg::MULH: begin
          s_b = {{32{rs2[31]}}, rs2};
          s_p = s_a * s_b;
          m_ext = s_p[63:32];
        end
        rv_wb_pkg::MULHSU: begin
          s_b = {32'b0, rs2};
          s_p = s_a * s_b;
          m_ext = s_p[63:32];
        end
        rv_wb_pkg::MULHU: m_ext = u_p[63:32];
        // Bit 2 set means a divide
        default: m_ext = div;
      endcase
      case (res_src)
        rv_wb_pkg::RES_ALU:   ref_rd_data = alu;
        rv_wb_pkg::RES_LOAD:  ref_rd_data = ld;
        rv_wb_pkg::RES_PC4:   ref_rd_data = pc4;
        rv_wb_pkg::RES_JBTGT: ref_rd_data = jb;
        rv_wb_pkg::RES_CSR:   ref_rd_data = csr;
        rv_wb_pkg::RES_MEXT:  ref_rd_data = m_ext;
        default:              ref_rd_data = '0;
      endcase
    end
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      data_errs++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Corner operands about a third of the time
  task automatic pick_operand(output logic [XLEN-1:0] v);
    logic [31:0] r;
    begin
      r = $random(seed);
      case (r[3:0])
        4'd0: v = 32'h0000_0000;
        4'd1: v = 32'h0000_0001;
        4'd2: v = 32'hffff_ffff;
        4'd3: v = 32'h8000_0000;
        4'd4: v = 32'h7fff_ffff;
        default: v = $random(seed);
      endcase
    end
  endtask

  task automatic drive_fields(input logic force_valid);
    logic [31:0]     r;
    logic [31:0]     pct;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    begin
      r = $random(seed);
      pct = {16'b0, r[15:0]} % 32'd100;
      s_valid_i <= force_valid || (pct < 32'd70);
      pick_operand(a);
      pick_operand(b);
      r = $random(seed);
      // Lean toward M-extension results
      res_src_wb_i    <= r[3] ? rv_wb_pkg::RES_MEXT : r[2:0];
      funct3_wb_i     <= r[6:4];
      trap_wb_i       <= r[7];
      trap_code_wb_i  <= r[9:8];
      ebreak_wb_i     <= r[10];
      reg_write_wb_i  <= r[11];
      instr_wb_i      <= $random(seed);
      alu_result_wb_i <= $random(seed);
      ld_data_wb_i    <= $random(seed);
      pc_plus4_wb_i   <= $random(seed);
      jb_tgt_wb_i     <= $random(seed);
      csr_rdata_wb_i  <= $random(seed);
      div_result_wb_i <= $random(seed);
      rs1_data_wb_i   <= a;
      rs2_data_wb_i   <= b;
      product_wb_i    <= {32'b0, a} * {32'b0, b};
    end
  endtask

  // Stimulus
  initial begin
    logic [31:0] r;
    logic [31:0] pct;
    reset_i = 1'b1;
    s_valid_i = 1'b0;
    m_ready_i = 1'b0;
    res_src_wb_i = '0;
    instr_wb_i = '0;
    alu_result_wb_i = '0;
    ld_data_wb_i = '0;
    pc_plus4_wb_i = '0;
    jb_tgt_wb_i = '0;
    csr_rdata_wb_i = '0;
    div_result_wb_i = '0;
    funct3_wb_i = '0;
    rs1_data_wb_i = '0;
    rs2_data_wb_i = '0;
    product_wb_i = '0;
    trap_wb_i = 1'b0;
    trap_code_wb_i = '0;
    ebreak_wb_i = 1'b0;
    reg_write_wb_i = 1'b0;
    repeat (8) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    assert (!m_valid_o && s_ready_o) else begin
      proto_errs++;
      $display("After reset the stage is not empty and ready at %0t ns", $time);
    end
    while (sent < NUM_TX) begin
      @(negedge clk);
      hold = s_valid_i && !s_ready_o;
      if (s_valid_i && s_ready_o) begin
        sent++;
      end
      burst = (sent >= BURST_LO) && (sent < BURST_HI);
      r = $random(seed);
      pct = {16'b0, r[15:0]} % 32'd100;
      @(posedge clk);
      m_ready_i <= burst || (pct < 32'd70);
      if (!hold) begin
        if (sent < NUM_TX) begin
          drive_fields(burst);
        end else begin
          s_valid_i <= 1'b0;
        end
      end
    end
    @(posedge clk);
    m_ready_i <= 1'b1;
    @(negedge clk);
    while (m_valid_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    assert (exp_q.size() == 0) else begin
      proto_errs++;
      $display("%0d accepted records were never retired", exp_q.size());
    end
    assert (max_streak >= 16) else begin
      proto_errs++;
      $display("Back-to-back transfers never ran at one per cycle, longest run %0d", max_streak);
    end
    $display("Errors: %0d data, %0d protocol; %0d accepted, %0d retired",
             data_errs, proto_errs, sent, retired);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Compare at the falling edge where everything is settled
  always @(negedge clk) begin
    if (!reset_i) begin
      exp_rd = ref_rd_data(res_src_wb_i, funct3_wb_i, alu_result_wb_i, ld_data_wb_i,
                           pc_plus4_wb_i, jb_tgt_wb_i, csr_rdata_wb_i, div_result_wb_i,
                           rs1_data_wb_i, rs2_data_wb_i);
      check_field("rd_data_wb_o", rd_data_wb_o, exp_rd);
      assert (s_ready_o == (!m_valid_o || m_ready_i)) else begin
        proto_errs++;
        $display("s_ready_o does not follow m_valid_o and m_ready_i at %0t ns", $time);
      end
      if (accepted_last) begin
        assert (m_valid_o) else begin
          proto_errs++;
          $display("Accepted input did not retire one cycle later at %0t ns", $time);
        end
      end
      if (!m_valid_o) begin
        assert (exp_q.size() == 0) else begin
          proto_errs++;
          $display("An accepted record was lost at %0t ns", $time);
        end
      end else begin
        assert (exp_q.size() != 0) else begin
          proto_errs++;
          $display("Record on the output with nothing expected at %0t ns", $time);
        end
        if (exp_q.size() != 0) begin
          cur_rec = exp_q[0];
          check_field("instr_ret_o", instr_ret_o, cur_rec.instr);
          check_field("pc_ret_o", pc_ret_o, cur_rec.pc);
          check_field("rs1_data_ret_o", rs1_data_ret_o, cur_rec.rs1);
          check_field("rs2_data_ret_o", rs2_data_ret_o, cur_rec.rs2);
          check_field("rd_data_ret_o", rd_data_ret_o, cur_rec.rd);
          check_field("trap_ret_o", 32'(trap_ret_o), 32'(cur_rec.trap));
          check_field("trap_code_ret_o", 32'(trap_code_ret_o), 32'(cur_rec.trap_code));
          check_field("reg_write_ret_o", 32'(reg_write_ret_o), 32'(cur_rec.reg_write));
          check_field("ebreak_ret_o", 32'(ebreak_ret_o), 32'(cur_rec.ebreak));
          if (m_ready_i) begin
            cur_rec = exp_q.pop_front();
            retired++;
          end
        end
      end
      accepted_last = s_valid_i && s_ready_o;
      if (accepted_last) begin
        new_rec.instr     = instr_wb_i;
        new_rec.pc        = pc_plus4_wb_i - 32'd4;
        new_rec.rs1       = rs1_data_wb_i;
        new_rec.rs2       = rs2_data_wb_i;
        new_rec.rd        = exp_rd;
        new_rec.trap      = trap_wb_i;
        new_rec.trap_code = trap_code_wb_i;
        new_rec.reg_write = reg_write_wb_i;
        new_rec.ebreak    = ebreak_wb_i;
        exp_q.push_back(new_rec);
        streak++;
        if (streak > max_streak) begin
          max_streak = streak;
        end
      end else begin
        streak = 0;
      end
    end
  end

  // Watchdog
  initial begin
    repeat (NUM_TX * 20 + 200) @(posedge clk);
    $display("Timeout: the run did not finish in time");
    $display("Some tests failed");
    $finish;
  end

endmodule

/* rv_stage_wb.sv */
`timescale 1ns/1ps

module rv_stage_wb #(
  parameter int XLEN = 32
) (
  input  logic                  clk,
  input  logic                  reset_i,

  // Handshake with the memory stage
  input  logic                  s_valid_i,
  output logic                  s_ready_o,

  // Fields from the memory stage
  input  rv_wb_pkg::res_src_t   res_src_wb_i,
  input  rv_wb_pkg::instr_t     instr_wb_i,
  input  logic [XLEN-1:0]       alu_result_wb_i,
  input  logic [XLEN-1:0]       ld_data_wb_i,
  input  logic [XLEN-1:0]       pc_plus4_wb_i,
  input  logic [XLEN-1:0]       jb_tgt_wb_i,
  input  logic [XLEN-1:0]       csr_rdata_wb_i,
  input  logic [XLEN-1:0]       div_result_wb_i,
  input  rv_wb_pkg::funct3_t    funct3_wb_i,
  input  logic [XLEN-1:0]       rs1_data_wb_i,
  input  logic [XLEN-1:0]       rs2_data_wb_i,
  input  logic [2*XLEN-1:0]     product_wb_i,
  input  logic                  trap_wb_i,
  input  rv_wb_pkg::trap_code_t trap_code_wb_i,
  input  logic                  ebreak_wb_i,
  input  logic                  reg_write_wb_i,

  // Handshake with the retirement consumer
  output logic                  m_valid_o,
  input  logic                  m_ready_i,

  // Retirement record
  output rv_wb_pkg::instr_t     instr_ret_o,
  output logic [XLEN-1:0]       pc_ret_o,
  output logic [XLEN-1:0]       rs1_data_ret_o,
  output logic [XLEN-1:0]       rs2_data_ret_o,
  output logic [XLEN-1:0]       rd_data_ret_o,
  output logic                  trap_ret_o,
  output rv_wb_pkg::trap_code_t trap_code_ret_o,
  output logic                  reg_write_ret_o,
  output logic                  ebreak_ret_o,

  // Same-cycle value for the register file write
  output logic [XLEN-1:0]       rd_data_wb_o
);

  logic [XLEN-1:0] mul_result;
  logic [XLEN-1:0] rd_data;
  logic            advance;

  // Sign correction of the unsigned product
  rv_mul_fixup #(
    .XLEN(XLEN)
  ) mul_fixup0 (
    .product_i   (product_wb_i),
    .rs1_data_i  (rs1_data_wb_i),
    .rs2_data_i  (rs2_data_wb_i),
    .funct3_i    (funct3_wb_i),
    .mul_result_o(mul_result)
  );

  // Final destination value
  rv_result_sel #(
    .XLEN(XLEN)
  ) result_sel0 (
    .res_src_i   (res_src_wb_i),
    .funct3_i    (funct3_wb_i),
    .alu_result_i(alu_result_wb_i),
    .ld_data_i   (ld_data_wb_i),
    .pc_plus4_i  (pc_plus4_wb_i),
    .jb_tgt_i    (jb_tgt_wb_i),
    .csr_rdata_i (csr_rdata_wb_i),
    .div_result_i(div_result_wb_i),
    .mul_result_i(mul_result),
    .rd_data_o   (rd_data)
  );

  assign rd_data_wb_o = rd_data;

  rv_pipe_ctrl pipe_ctrl0 (
    .clk      (clk),
    .reset_i  (reset_i),
    .s_valid_i(s_valid_i),
    .m_ready_i(m_ready_i),
    .s_ready_o(s_ready_o),
    .m_valid_o(m_valid_o),
    .advance_o(advance)
  );

  // One-deep holding register for the retiring instruction
  rv_retire_reg #(
    .XLEN(XLEN)
  ) retire_reg0 (
    .clk        (clk),
    .reset_i    (reset_i),
    .advance_i  (advance),
    .instr_i    (instr_wb_i),
    .pc_plus4_i (pc_plus4_wb_i),
    .rs1_data_i (rs1_data_wb_i),
    .rs2_data_i (rs2_data_wb_i),
    .rd_data_i  (rd_data),
    .trap_i     (trap_wb_i),
    .trap_code_i(trap_code_wb_i),
    .reg_write_i(reg_write_wb_i),
    .ebreak_i   (ebreak_wb_i),
    .instr_o    (instr_ret_o),
    .pc_o       (pc_ret_o),
    .rs1_data_o (rs1_data_ret_o),
    .rs2_data_o (rs2_data_ret_o),
    .rd_data_o  (rd_data_ret_o),
    .trap_o     (trap_ret_o),
    .trap_code_o(trap_code_ret_o),
    .reg_write_o(reg_write_ret_o),
    .ebreak_o   (ebreak_ret_o)
  );

endmodule

/* rv_retire_reg.sv */
`timescale 1ns/1ps

module rv_retire_reg #(
  parameter int XLEN = 32
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  advance_i,
  input  rv_wb_pkg::instr_t     instr_i,
  input  logic [XLEN-1:0]       pc_plus4_i,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  logic [XLEN-1:0]       rd_data_i,
  input  logic                  trap_i,
  input  rv_wb_pkg::trap_code_t trap_code_i,
  input  logic                  reg_write_i,
  input  logic                  ebreak_i,
  output rv_wb_pkg::instr_t     instr_o,
  output logic [XLEN-1:0]       pc_o,
  output logic [XLEN-1:0]       rs1_data_o,
  output logic [XLEN-1:0]       rs2_data_o,
  output logic [XLEN-1:0]       rd_data_o,
  output logic                  trap_o,
  output rv_wb_pkg::trap_code_t trap_code_o,
  output logic                  reg_write_o,
  output logic                  ebreak_o
);

  logic [XLEN-1:0] pc_cur;

  // Recover the instruction address from the link value
  assign pc_cur = pc_plus4_i - XLEN'(32'd4);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      instr_o     <= '0;
      pc_o        <= '0;
      rs1_data_o  <= '0;
      rs2_data_o  <= '0;
      rd_data_o   <= '0;
      trap_o      <= 1'b0;
      trap_code_o <= '0;
      reg_write_o <= 1'b0;
      ebreak_o    <= 1'b0;
    end else if (advance_i) begin
      instr_o     <= instr_i;
      pc_o        <= pc_cur;
      rs1_data_o  <= rs1_data_i;
      rs2_data_o  <= rs2_data_i;
      rd_data_o   <= rd_data_i;
      trap_o      <= trap_i;
      trap_code_o <= trap_code_i;
      reg_write_o <= reg_write_i;
      ebreak_o    <= ebreak_i;
    end
  end

endmodule

/* rv_pipe_ctrl.sv */
`timescale 1ns/1ps

module rv_pipe_ctrl (
  input  logic clk,
  input  logic reset_i,
  input  logic s_valid_i,
  input  logic m_ready_i,
  output logic s_ready_o,
  output logic m_valid_o,
  output logic advance_o
);

  logic m_valid_q;

  // Room for a new record when empty or when the current one leaves now
  assign s_ready_o = !m_valid_q || m_ready_i;

  // Transfer from the memory stage, the single load enable
  assign advance_o = s_valid_i && s_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      m_valid_q <= 1'b0;
    end else if (advance_o) begin
      m_valid_q <= 1'b1;
    end else if (m_ready_i) begin
      // Record consumed and nothing new behind it
      m_valid_q <= 1'b0;
    end
  end

  assign m_valid_o = m_valid_q;

endmodule

/* rv_result_sel.sv */
`timescale 1ns/1ps

module rv_result_sel #(
  parameter int XLEN = 32
) (
  input  rv_wb_pkg::res_src_t res_src_i,
  input  rv_wb_pkg::funct3_t  funct3_i,
  input  logic [XLEN-1:0]     alu_result_i,
  input  logic [XLEN-1:0]     ld_data_i,
  input  logic [XLEN-1:0]     pc_plus4_i,
  input  logic [XLEN-1:0]     jb_tgt_i,
  input  logic [XLEN-1:0]     csr_rdata_i,
  input  logic [XLEN-1:0]     div_result_i,
  input  logic [XLEN-1:0]     mul_result_i,
  output logic [XLEN-1:0]     rd_data_o
);

  logic [XLEN-1:0] m_ext_result;

  // Divider finishes upstream, multiply is completed in this stage
  assign m_ext_result = funct3_i[rv_wb_pkg::F3_DIV_BIT] ? div_result_i : mul_result_i;

  always_comb begin
    case (res_src_i)
      rv_wb_pkg::RES_ALU: begin
        rd_data_o = alu_result_i;
      end
      rv_wb_pkg::RES_LOAD: begin
        rd_data_o = ld_data_i;
      end
      rv_wb_pkg::RES_PC4: begin
        rd_data_o = pc_plus4_i;
      end
      rv_wb_pkg::RES_JBTGT: begin
        rd_data_o = jb_tgt_i;
      end
      rv_wb_pkg::RES_CSR: begin
        rd_data_o = csr_rdata_i;
      end
      rv_wb_pkg::RES_MEXT: begin
        rd_data_o = m_ext_result;
      end
      default: begin
        rd_data_o = '0;
      end
    endcase
  end

endmodule

/* rv_mul_fixup.sv */
`timescale 1ns/1ps

module rv_mul_fixup #(
  parameter int XLEN = 32
) (
  input  logic [2*XLEN-1:0]      product_i,
  input  logic [XLEN-1:0]        rs1_data_i,
  input  logic [XLEN-1:0]        rs2_data_i,
  input  rv_wb_pkg::funct3_t     funct3_i,
  output logic [XLEN-1:0]        mul_result_o
);

  logic [XLEN-1:0] prod_lo;
  logic [XLEN-1:0] prod_hi;
  logic            rs1_neg;
  logic            rs2_neg;
  logic [XLEN-1:0] corr_rs1;
  logic [XLEN-1:0] corr_rs2;

  assign prod_lo = product_i[XLEN-1:0];
  assign prod_hi = product_i[2*XLEN-1:XLEN];

  assign rs1_neg = rs1_data_i[XLEN-1];
  assign rs2_neg = rs2_data_i[XLEN-1];

  // A negative rs1 read as unsigned adds rs2 * 2^XLEN to the product,
  // so that term has to come back out of the high half
  assign corr_rs1 = rs1_neg ? rs2_data_i : '0;

  // Same for a negative rs2, only used by the fully signed form
  assign corr_rs2 = rs2_neg ? rs1_data_i : '0;

  always_comb begin
    case (funct3_i)
      rv_wb_pkg::MUL_LO: begin
        mul_result_o = prod_lo;
      end
      rv_wb_pkg::MULH: begin
        mul_result_o = prod_hi - corr_rs1 - corr_rs2;
      end
      rv_wb_pkg::MULHSU: begin
        mul_result_o = prod_hi - corr_rs1;
      end
      rv_wb_pkg::MULHU: begin
        mul_result_o = prod_hi;
      end
      default: begin
        // Divide codes, the result selector ignores this value
        mul_result_o = prod_lo;
      end
    endcase
  end

endmodule

/* rv_wb_pkg.sv */
package rv_wb_pkg;

  // Raw instruction word as fetched
  typedef logic [31:0] instr_t;

  // Write-back result source select
  typedef logic [2:0] res_src_t;

  // Instruction funct3 field
  typedef logic [2:0] funct3_t;

  // Trap cause carried with a retiring instruction
  typedef logic [1:0] trap_code_t;

  // Result source codes; 6 and 7 are unused and give zero
  localparam res_src_t RES_ALU   = 3'd0;
  localparam res_src_t RES_LOAD  = 3'd1;
  localparam res_src_t RES_PC4   = 3'd2;
  localparam res_src_t RES_JBTGT = 3'd3;
  localparam res_src_t RES_CSR   = 3'd4;
  localparam res_src_t RES_MEXT  = 3'd5;

  // Multiply flavours in funct3
  localparam funct3_t MUL_LO = 3'd0;
  localparam funct3_t MULH   = 3'd1;
  localparam funct3_t MULHSU = 3'd2;
  localparam funct3_t MULHU  = 3'd3;

  // funct3 bit that marks a divide or remainder
  localparam int F3_DIV_BIT = 2;

endpackage
